// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;

    // rv64 major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_IMM_W  = 7'b0011011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_REG_W  = 7'b0111011;

    typedef logic [XLEN-1:0]             xlen_t;
    typedef logic [31:0]                 inst_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [10:0]                 alu_op_t;   // lui sra srl sll xor or and sltu slt sub add
    typedef logic [1:0]                  src1_sel_t; // pc rs1
    typedef logic [4:0]                  src2_sel_t; // 4 imm_s imm_u imm_i rs2
    typedef logic [6:0]                  npc_sel_t;  // bge blt bne beq jalr jal seq
    typedef logic [3:0]                  mem_mask_t; // byte half word double

    typedef struct packed {
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        npc_sel_t  npc_sel;
        logic      cmp_unsigned;
        logic      word;
        logic      rf_we;
        logic      mem_ena;
        logic      mem_wen;
        mem_mask_t mem_mask;
        logic      load_unsigned;
        logic      illegal;
        xlen_t     imm;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        reg_idx_t  rd;
        logic      rd_we;
        xlen_t     rd_value;
        xlen_t     next_pc;
        logic      mem_ena;
        logic      mem_wen;
        xlen_t     mem_addr;
        xlen_t     mem_wdata;
        mem_mask_t mem_mask;
    } retire_t;

endpackage

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decoder
    import rv_pkg::*;
(
    input  inst_t inst,
    output ctrl_t ctrl
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero, f7_alt, sh_zero, sh_alt;
    logic       op_reg, op_reg_w, op_imm, op_imm_w, arith, reg_form;
    logic       inst_lui, inst_auipc, inst_jal, inst_jalr;
    logic       branch, load, store;
    xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign f7_zero = funct7 == 7'b0000000;
    assign f7_alt  = funct7 == 7'b0100000;
    assign sh_zero = funct7[6:1] == 6'b000000; // rv64 shamt reaches bit 25
    assign sh_alt  = funct7[6:1] == 6'b010000;

    // arithmetic classes accept only the legal funct7 per funct3
    assign op_reg = (opcode == OP_REG)
                  & (f7_zero | (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101))));
    assign op_reg_w = (opcode == OP_REG_W)
                    & ((f7_zero & ((funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b101)))
                    | (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101))));
    assign op_imm = (opcode == OP_IMM)
                  & ((funct3 == 3'b001) ? sh_zero :
                     (funct3 == 3'b101) ? (sh_zero | sh_alt) : 1'b1);
    assign op_imm_w = (opcode == OP_IMM_W)
                    & ((funct3 == 3'b000) | ((funct3 == 3'b001) & f7_zero)
                    | ((funct3 == 3'b101) & (f7_zero | f7_alt)));
    assign arith    = op_reg | op_reg_w | op_imm | op_imm_w;
    assign reg_form = op_reg | op_reg_w;

    assign inst_lui   = opcode == OP_LUI;
    assign inst_auipc = opcode == OP_AUIPC;
    assign inst_jal   = opcode == OP_JAL;
    assign inst_jalr  = (opcode == OP_JALR) & (funct3 == 3'b000);
    assign branch     = (opcode == OP_BRANCH) & (funct3[2:1] != 2'b01);
    assign load       = (opcode == OP_LOAD) & (funct3 != 3'b111);
    assign store      = (opcode == OP_STORE) & ~funct3[2];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign ctrl.alu_op = {inst_lui,
                          arith & (funct3 == 3'b101) & inst[30],      // sra
                          arith & (funct3 == 3'b101) & ~inst[30],     // srl
                          arith & (funct3 == 3'b001),
                          arith & (funct3 == 3'b100),
                          arith & (funct3 == 3'b110),
                          arith & (funct3 == 3'b111),
                          (arith & (funct3 == 3'b011)) | (branch & funct3[1]),
                          (arith & (funct3 == 3'b010)) | (branch & funct3[2] & ~funct3[1]),
                          (arith & (funct3 == 3'b000) & reg_form & inst[30])
                              | (branch & ~funct3[2]),
                          (arith & (funct3 == 3'b000) & ~(reg_form & inst[30]))
                              | inst_auipc | inst_jal | inst_jalr | load | store};

    assign ctrl.src1_sel = {inst_auipc | inst_jal | inst_jalr,
                            arith | branch | load | store};
    assign ctrl.src2_sel = {inst_jal | inst_jalr,
                            store,
                            inst_lui | inst_auipc,
                            op_imm | op_imm_w | load,
                            reg_form | branch};
    assign ctrl.npc_sel = {branch & funct3[2] & funct3[0],
                           branch & funct3[2] & ~funct3[0],
                           branch & (funct3 == 3'b001),
                           branch & (funct3 == 3'b000),
                           inst_jalr,
                           inst_jal,
                           ~(inst_jal | inst_jalr | branch)}; // illegal falls through too

    assign ctrl.cmp_unsigned  = branch & funct3[1];
    assign ctrl.word          = op_reg_w | op_imm_w;
    assign ctrl.rf_we         = arith | inst_lui | inst_auipc | inst_jal | inst_jalr | load;
    assign ctrl.mem_ena       = load | store;
    assign ctrl.mem_wen       = store;
    // funct3[1:0] is log2 of the size so 3 gives double in bit 0
    assign ctrl.mem_mask      = (load | store) ? (4'b0001 << (2'd3 - funct3[1:0])) : 4'b0000;
    assign ctrl.load_unsigned = load & funct3[2];
    assign ctrl.illegal       = ~(arith | inst_lui | inst_auipc | inst_jal | inst_jalr
                                | branch | load | store);
    assign ctrl.imm = store                   ? imm_s :
                      branch                  ? imm_b :
                      (inst_lui | inst_auipc) ? imm_u :
                      inst_jal                ? imm_j : imm_i;

    always_comb begin
        assert ($onehot0(ctrl.alu_op));
        assert ($onehot0(ctrl.mem_mask));
        assert (!(ctrl.illegal && ctrl.rf_we));
    end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_data
);
    xlen_t regs [1:NUM_REGS-1]; // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
        ((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0)));

endmodule

`default_nettype wire

// File: rv_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  ctrl_t ctrl,
    input  xlen_t pc,
    input  xlen_t rs1_data,
    input  xlen_t rs2_data,
    output xlen_t result,
    output xlen_t sum
);
    xlen_t      op_a, op_b;
    xlen_t      srl_src, sra_src, sra_res, raw;
    logic [5:0] shamt;

    assign op_a = ({XLEN{ctrl.src1_sel[0]}} & rs1_data)
                | ({XLEN{ctrl.src1_sel[1]}} & pc);
    // decoder already picked the class immediate
    assign op_b = ({XLEN{ctrl.src2_sel[0]}} & rs2_data)
                | ({XLEN{|ctrl.src2_sel[3:1]}} & ctrl.imm)
                | ({XLEN{ctrl.src2_sel[4]}} & xlen_t'(4));

    // word ops shift only the low half
    assign shamt   = ctrl.word ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign srl_src = ctrl.word ? {32'b0, op_a[31:0]} : op_a;
    assign sra_src = ctrl.word ? {{32{op_a[31]}}, op_a[31:0]} : op_a;
    assign sra_res = $signed(sra_src) >>> shamt;

    assign raw = ({XLEN{ctrl.alu_op[0]}}  & (op_a + op_b))
               | ({XLEN{ctrl.alu_op[1]}}  & (op_a - op_b))
               | ({XLEN{ctrl.alu_op[2]}}  & xlen_t'($signed(op_a) < $signed(op_b)))
               | ({XLEN{ctrl.alu_op[3]}}  & xlen_t'(op_a < op_b))
               | ({XLEN{ctrl.alu_op[4]}}  & (op_a & op_b))
               | ({XLEN{ctrl.alu_op[5]}}  & (op_a | op_b))
               | ({XLEN{ctrl.alu_op[6]}}  & (op_a ^ op_b))
               | ({XLEN{ctrl.alu_op[7]}}  & (op_a << shamt))
               | ({XLEN{ctrl.alu_op[8]}}  & (srl_src >> shamt))
               | ({XLEN{ctrl.alu_op[9]}}  & sra_res)
               | ({XLEN{ctrl.alu_op[10]}} & op_b);    // lui passes imm_u

    assign result = ctrl.word ? {{32{raw[31]}}, raw[31:0]} : raw;

    // separate address adder, jumps use the main one for pc+4
    assign sum = rs1_data + ctrl.imm;

endmodule

`default_nettype wire

// File: rv_next_pc.sv
`timescale 1ns/100ps
`default_nettype none

module rv_next_pc
    import rv_pkg::*;
(
    input  ctrl_t ctrl,
    input  xlen_t pc,
    input  xlen_t rs1_data,
    input  xlen_t rs2_data,
    input  xlen_t sum,
    output xlen_t next_pc
);
    logic  eq, lt, is_branch, cond;
    xlen_t seq_pc, rel_pc;

    assign eq = rs1_data == rs2_data;
    assign lt = ctrl.cmp_unsigned ? (rs1_data < rs2_data)
                                  : ($signed(rs1_data) < $signed(rs2_data));

    assign is_branch = |ctrl.npc_sel[6:3];
    assign cond = (ctrl.npc_sel[3] & eq) | (ctrl.npc_sel[4] & ~eq)
                | (ctrl.npc_sel[5] & lt) | (ctrl.npc_sel[6] & ~lt);

    assign seq_pc = pc + xlen_t'(4);
    assign rel_pc = pc + ctrl.imm;    // jal and branch targets

    assign next_pc = ({XLEN{ctrl.npc_sel[0] | (is_branch & ~cond)}} & seq_pc)
                   | ({XLEN{ctrl.npc_sel[1] | cond}} & rel_pc)
                   | ({XLEN{ctrl.npc_sel[2]}} & {sum[XLEN-1:1], 1'b0});

endmodule

`default_nettype wire

// File: rv_exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_core
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  inst_t   in_inst,
    input  xlen_t   in_pc,
    output retire_t retire
);
    ctrl_t   ctrl;
    xlen_t   rs1_data, rs2_data, result, sum, next_pc;
    logic    issue;
    retire_t retire_d;

    assign issue = in_valid & ~ctrl.illegal;

    rv_decoder i_decoder (
        .inst (in_inst),
        .ctrl (ctrl)
    );

    rv_regfile i_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (in_inst[19:15]),
        .rs2      (in_inst[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (issue & ctrl.rf_we),
        .wr_idx   (in_inst[11:7]),
        .wr_data  (result)
    );

    rv_alu i_alu (
        .ctrl     (ctrl),
        .pc       (in_pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (result),
        .sum      (sum)
    );

    rv_next_pc i_next_pc (
        .ctrl     (ctrl),
        .pc       (in_pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .sum      (sum),
        .next_pc  (next_pc)
    );

    always_comb begin
        retire_d           = '0;
        retire_d.valid     = in_valid;
        retire_d.illegal   = in_valid & ctrl.illegal;
        retire_d.rd        = in_inst[11:7];
        retire_d.rd_we     = issue & ctrl.rf_we;
        retire_d.rd_value  = result;  // loads report their address
        retire_d.next_pc   = next_pc;
        retire_d.mem_ena   = issue & ctrl.mem_ena;
        retire_d.mem_wen   = issue & ctrl.mem_wen;
        retire_d.mem_addr  = sum;
        retire_d.mem_wdata = rs2_data;
        retire_d.mem_mask  = ctrl.mem_mask;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire <= retire_d;
        end
    end

    // the next instruction reads the value written at the issue edge
    a_write_then_read: assert property (@(posedge clk) disable iff (!arst_n)
        (issue && ctrl.rf_we && (in_inst[11:7] != '0))
            |=> ((in_inst[19:15] != $past(in_inst[11:7])) || (rs1_data == $past(result))));

endmodule

`default_nettype wire

// File: tb_rv_exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_exec_core
    import rv_pkg::*;
();
    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 10;
    localparam string VECTOR_FILE  = "rv_exec_core_input.txt";

    typedef struct packed {
        logic    valid;
        inst_t   inst;
        xlen_t   pc;
        retire_t exp_rec;
    } vector_t;

    logic    clk, arst_n, in_valid;
    inst_t   in_inst;
    xlen_t   in_pc;
    retire_t retire;
    vector_t vectors [$];
    bit      loaded = 1'b0;

    rv_exec_core i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .in_pc    (in_pc),
        .retire   (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "retire record differs from the expected one");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic load_vectors();
        int          fd;
        int          count;
        string       line;
        vector_t     vec;
        logic [63:0] v, inst, pc, e_v, e_ill, e_we, e_rd, e_val, e_npc, e_ena, e_wen, e_addr,
                     e_wdata, e_mask;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) abort_run({"cannot open the vector file ", VECTOR_FILE});
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue;
            count = $sscanf(line, "%h %h %h %h %h %h %d %h %h %h %h %h %h %h", v, inst, pc,
                            e_v, e_ill, e_we, e_rd, e_val, e_npc, e_ena, e_wen, e_addr,
                            e_wdata, e_mask);
            if (count <= 0) continue;  // blank line
            if (count != 14) abort_run({"malformed vector line: ", line});
            vec = '{valid: v[0], inst: inst[31:0], pc: pc, exp_rec: '{valid: e_v[0],
                    illegal: e_ill[0], rd: e_rd[4:0], rd_we: e_we[0], rd_value: e_val,
                    next_pc: e_npc, mem_ena: e_ena[0], mem_wen: e_wen[0], mem_addr: e_addr,
                    mem_wdata: e_wdata, mem_mask: e_mask[3:0]}};
            vectors.push_back(vec);
        end
        $fclose(fd);
        if (vectors.size() == 0) abort_run("the vector file holds no vectors");
    endtask

    // fields that do not apply to an instruction are left unchecked
    task automatic check_retire(input retire_t exp_rec);
        check_field("valid", 64'(exp_rec.valid), 64'(retire.valid));
        check_field("illegal", 64'(exp_rec.illegal), 64'(retire.illegal));
        check_field("rd_we", 64'(exp_rec.rd_we), 64'(retire.rd_we));
        check_field("mem_ena", 64'(exp_rec.mem_ena), 64'(retire.mem_ena));
        check_field("mem_wen", 64'(exp_rec.mem_wen), 64'(retire.mem_wen));
        check_field("mem_mask", 64'(exp_rec.mem_mask), 64'(retire.mem_mask));
        if (exp_rec.valid) check_field("next_pc", exp_rec.next_pc, retire.next_pc);
        if (exp_rec.rd_we) begin
            check_field("rd", 64'(exp_rec.rd), 64'(retire.rd));
            check_field("rd_value", exp_rec.rd_value, retire.rd_value);
        end
        if (exp_rec.mem_ena) check_field("mem_addr", exp_rec.mem_addr, retire.mem_addr);
        if (exp_rec.mem_wen) check_field("mem_wdata", exp_rec.mem_wdata, retire.mem_wdata);
    endtask

    initial begin
        int n;
        in_valid = 1'b0;
        in_inst  = '0;
        in_pc    = '0;
        arst_n   = 1'b0;
        load_vectors();
        loaded = 1'b1;
        n = vectors.size();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        // record of line i shows up one falling edge after it is driven
        for (int i = 0; i <= n; i++) begin
            @(negedge clk);
            if (i > 0) check_retire(vectors[i-1].exp_rec);
            in_valid = (i < n) ? vectors[i].valid : 1'b0;
            in_inst  = (i < n) ? vectors[i].inst : 32'h0000_0013;
            in_pc    = (i < n) ? vectors[i].pc : '0;
        end
        $display("checked %0d retire records", n);
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        int unsigned limit;
        wait (loaded);
        limit = vectors.size() + 20;
        #(limit * CLK_PERIOD);
        abort_run($sformatf("timeout: the run did not end within %0d clock cycles", limit));
    end

endmodule

`default_nettype wire

// File: rv_exec_core_input.txt
# in_valid inst pc | valid illegal rd_we rd rd_value next_pc mem_ena mem_wen mem_addr wdata mask
# all fields hex except rd (decimal); fields that do not apply hold 0
1 123450B7 1000 1 0 1 1 0000000012345000 1004 0 0 0 0 0
1 67808093 1004 1 0 1 1 0000000012345678 1008 0 0 0 0 0
1 FFF00113 1008 1 0 1 2 FFFFFFFFFFFFFFFF 100C 0 0 0 0 0
1 7FF0819B 100C 1 0 1 3 0000000012345E77 1010 0 0 0 0 0
1 80000237 1010 1 0 1 4 FFFFFFFF80000000 1014 0 0 0 0 0
1 FFF2029B 1014 1 0 1 5 000000007FFFFFFF 1018 0 0 0 0 0
1 00308333 1018 1 0 1 6 000000002468B4EF 101C 0 0 0 0 0
1 401003B3 101C 1 0 1 7 FFFFFFFFEDCBA988 1020 0 0 0 0 0
1 00512433 1020 1 0 1 8 0000000000000001 1024 0 0 0 0 0
1 005134B3 1024 1 0 1 9 0000000000000000 1028 0 0 0 0 0
1 FFF0C513 1028 1 0 1 10 FFFFFFFFEDCBA987 102C 0 0 0 0 0
1 00526633 1030 1 0 1 12 FFFFFFFFFFFFFFFF 1034 0 0 0 0 0
1 02409693 1034 1 0 1 13 2345678000000000 1038 0 0 0 0 0
1 40425713 1038 1 0 1 14 FFFFFFFFF8000000 103C 0 0 0 0 0
1 4082583B 1040 1 0 1 16 FFFFFFFFC0000000 1044 0 0 0 0 0
1 008288BB 1044 1 0 1 17 FFFFFFFF80000000 1048 0 0 0 0 0
1 00508013 1048 1 0 1 0 000000001234567D 104C 0 0 0 0 0
1 00200933 104C 1 0 1 18 FFFFFFFFFFFFFFFF 1050 0 0 0 0 0
1 00001997 1050 1 0 1 19 0000000000002050 1054 0 0 0 0 0
1 02000A6F 1054 1 0 1 20 0000000000001058 1074 0 0 0 0 0
1 00708AE7 1074 1 0 1 21 0000000000001078 1234567E 0 0 0 0 0
1 01210863 2000 1 0 0 0 0 2010 0 0 0 0 0
1 FE309CE3 2004 1 0 0 0 0 1FFC 0 0 0 0 0
1 00514863 2008 1 0 0 0 0 2018 0 0 0 0 0
1 00516863 200C 1 0 0 0 0 2010 0 0 0 0 0
1 FE515CE3 2010 1 0 0 0 0 2014 0 0 0 0 0
1 FE517CE3 2014 1 0 0 0 0 200C 0 0 0 0 0
1 0080BB03 3000 1 0 1 22 0000000012345680 3004 1 0 12345680 0 1
1 FFF0CB83 3004 1 0 1 23 0000000012345677 3008 1 0 12345677 0 8
1 0020B823 3008 1 0 0 0 0 300C 1 1 12345688 FFFFFFFFFFFFFFFF 1
1 FE30AE23 300C 1 0 0 0 0 3010 1 1 12345674 0000000012345E77 2
1 00701123 3010 1 0 0 0 0 3014 1 1 2 FFFFFFFFEDCBA988 4
1 00128023 3014 1 0 0 0 0 3018 1 1 7FFFFFFF 0000000012345678 8
1 02308C3B 4000 1 1 0 0 0 4004 0 0 0 0 0
1 FFFFFFFF 4004 1 1 0 0 0 4008 0 0 0 0 0
0 00000013 0 0 0 0 0 0 0 0 0 0 0 0
1 06400C93 5000 1 0 1 25 0000000000000064 5004 0 0 0 0 0
1 401C8D33 5004 1 0 1 26 FFFFFFFFEDCBA9EC 5008 0 0 0 0 0

// File: rv_exec_core.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_next_pc.sv
rv_exec_core.sv
tb_rv_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_exec_core -f rv_exec_core.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rv_exec_core 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "$out" | grep -qx "STATUS: PASS" || exit 1
exit 0
